/* list.f */
hdl/cpuTypesPkg.sv
hdl/cpuIsaPkg.sv
hdl/cpuControl.sv
hdl/cpuFetch.sv
hdl/cpuRegFile.sv
hdl/cpuAlu.sv
hdl/cpuDataMem.sv
hdl/cpuTop.sv
tests/cpuTop_props.sv
tests/cpuTb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := cpuTb
FILELIST  := list.f
LOG       := sim.log
PASS_MSG  := Done: no errors
FAIL_MSG  := Done: errors found

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* tests/cpuTb.sv */
// CPU directed testbench
`timescale 1ns/1ps
module cpuTb import cpuTypesPkg::*; ();

	logic clk, rstN, run, imemWe;
	pc_t imemAddr;
	instr_t imemData;
	pc_t pc;
	logic regWe, memWe;
	regAddr_t regWrAddr;
	word_t regWrData, memAddr, memWrData;
	flags_t flags;

	int errors;
	flags_t f;
	instr_t prog[$];
	logic eWe[$];
	regAddr_t eAddr[$];
	word_t eData[$];
	flags_t eFlags[$];
	logic eMemWe[$];
	word_t eMemAddr[$];
	word_t eMemData[$];

	localparam instr_t nopInstr = 16'hBF00;
	localparam instr_t undefInstr = 16'hE800;

	cpuTop #(.imemAddrBits(8), .dmemAddrBits(6)) UUT (.clk, .rstN, .run, .imemWe, .imemAddr,
		.imemData, .pc, .regWe, .regWrAddr, .regWrData, .memWe, .memAddr, .memWrData, .flags);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Hard stop in case a wait loop is broken
	initial begin
		#1ms;
		$display("Simulation ran past its time limit");
		$display("Done: errors found");
		$finish;
	end

	function automatic instr_t encMovs(regAddr_t rd, logic [7:0] imm);
		return {5'b00100, rd, imm};
	endfunction

	// kind: 00 add reg, 01 sub reg, 10 add imm3, 11 sub imm3
	function automatic instr_t encAddSub(logic [1:0] kind, regAddr_t rd, regAddr_t rn,
		logic [2:0] rmImm);
		return {5'b00011, kind, rmImm, rn, rd};
	endfunction

	function automatic instr_t encDp(logic [3:0] op, regAddr_t rdn, regAddr_t rm);
		return {6'b010000, op, rm, rdn};
	endfunction

	function automatic instr_t encMem(logic isLoad, regAddr_t rt, regAddr_t rn, logic [4:0] imm);
		return {4'b0110, isLoad, imm, rn, rt};
	endfunction

	function automatic flags_t arithFlags(word_t a, word_t b, logic isSub);
		logic [32:0] wide;
		flags_t fl;
		if (isSub) begin
			wide = {1'b0, a} - {1'b0, b};
			fl[flagC] = (a >= b);
			fl[flagV] = (a[31] != b[31]) && (wide[31] != a[31]);
		end else begin
			wide = {1'b0, a} + {1'b0, b};
			fl[flagC] = wide[32];
			fl[flagV] = (a[31] == b[31]) && (wide[31] != a[31]);
		end
		fl[flagN] = wide[31];
		fl[flagZ] = (wide[31:0] == 32'd0);
		return fl;
	endfunction

	function automatic flags_t nzFlags(word_t r, flags_t prev);
		flags_t fl;
		fl = prev;
		fl[flagN] = r[31];
		fl[flagZ] = (r == 32'd0);
		return fl;
	endfunction

	// dir: 0 LSL, 1 LSR, 2 ASR, 3 ROR
	function automatic word_t shiftModel(int dir, word_t a, logic [7:0] amt);
		int rot;
		rot = amt % 32;
		case (dir)
			0: return (amt >= 32) ? 32'd0 : a << amt;
			1: return (amt >= 32) ? 32'd0 : a >> amt;
			2: return (amt >= 32) ? {32{a[31]}} : word_t'($signed(a) >>> amt);
			default: return (rot == 0) ? a : (a >> rot) | (a << (32 - rot));
		endcase
	endfunction

	function automatic logic condModel(int c, flags_t fl);
		logic n, z, cy, v;
		{n, z, cy, v} = {fl[flagN], fl[flagZ], fl[flagC], fl[flagV]};
		case (c)
			0: return z;
			1: return !z;
			2: return cy;
			3: return !cy;
			4: return n;
			5: return !n;
			6: return v;
			7: return !v;
			8: return cy && !z;
			9: return !cy || z;
			10: return n == v;
			11: return n != v;
			12: return !z && (n == v);
			13: return z || (n != v);
			default: return 1'b1;
		endcase
	endfunction

	task automatic checkWord(string name, word_t exp, word_t act);
		if (exp !== act) begin
			$display("[ERROR] %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic checkPc(string name, pc_t exp, pc_t act);
		if (exp !== act) begin
			$display("[ERROR] %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic checkReg(string name, regAddr_t exp, regAddr_t act);
		if (exp !== act) begin
			$display("[ERROR] %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic checkFlags(string name, flags_t exp, flags_t act);
		if (exp !== act) begin
			$display("[ERROR] %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic checkBit(string name, logic exp, logic act);
		if (exp !== act) begin
			$display("[ERROR] %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic clearProgram();
		prog.delete();
		eWe.delete();
		eAddr.delete();
		eData.delete();
		eFlags.delete();
		eMemWe.delete();
		eMemAddr.delete();
		eMemData.delete();
	endtask

	task automatic emit(instr_t i, logic we, regAddr_t ad, word_t d, logic mWe, word_t mAd,
		word_t mD);
		prog.push_back(i);
		eWe.push_back(we);
		eAddr.push_back(ad);
		eData.push_back(d);
		eFlags.push_back(f);
		eMemWe.push_back(mWe);
		eMemAddr.push_back(mAd);
		eMemData.push_back(mD);
	endtask

	task automatic emitReg(instr_t i, regAddr_t ad, word_t d);
		emit(i, 1'b1, ad, d, 1'b0, 32'd0, 32'd0);
	endtask

	task automatic emitNone(instr_t i);
		emit(i, 1'b0, 3'd0, 32'd0, 1'b0, 32'd0, 32'd0);
	endtask

	// Reset, write the program while stalled, then release run
	task automatic loadAndStart();
		run = 1'b0;
		imemWe = 1'b0;
		rstN = 1'b0;
		repeat (3) @(posedge clk);
		#1 rstN = 1'b1;
		foreach (prog[k]) begin
			imemWe = 1'b1;
			imemAddr = pc_t'(k);
			imemData = prog[k];
			@(posedge clk);
			#1;
		end
		imemWe = 1'b0;
		run = 1'b1;
	endtask

	task automatic runExpected();
		foreach (eWe[k]) begin
			@(negedge clk);
			checkPc("pc", pc_t'(k), pc);
			checkBit("regWe", eWe[k], regWe);
			if (eWe[k]) begin
				checkReg("regWrAddr", eAddr[k], regWrAddr);
				checkWord("regWrData", eData[k], regWrData);
			end
			checkBit("memWe", eMemWe[k], memWe);
			if (eMemWe[k]) begin
				checkWord("memAddr", eMemAddr[k], memAddr);
				checkWord("memWrData", eMemData[k], memWrData);
			end
			@(posedge clk);
			#1;
			checkFlags("flags", eFlags[k], flags);
		end
		run = 1'b0;
	endtask

	task automatic waitPc(pc_t target, int limit);
		int n;
		n = 0;
		while (pc !== target && n < limit) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (pc !== target) begin
			$display("Timed out waiting for the PC to reach %h", target);
			errors++;
		end
	endtask

	task automatic stepCheck(pc_t expPc, logic expWe, pc_t nextPc);
		@(negedge clk);
		checkPc("pc", expPc, pc);
		checkBit("regWe", expWe, regWe);
		checkBit("memWe", 1'b0, memWe);
		@(posedge clk);
		#1;
		checkPc("pc", nextPc, pc);
	endtask

	task automatic testArith();
		word_t a, b, c;
		clearProgram();
		f = '0;
		f = nzFlags(32'd1, f);
		emitReg(encMovs(3'd0, 8'd1), 3'd0, 32'd1);
		f = nzFlags(32'd31, f);
		emitReg(encMovs(3'd1, 8'd31), 3'd1, 32'd31);
		a = shiftModel(0, 32'd1, 8'd31);
		f = nzFlags(a, f);
		emitReg(encDp(4'b0010, 3'd0, 3'd1), 3'd0, a);
		b = a - 32'd1;
		f = arithFlags(a, 32'd1, 1'b1);
		emitReg(encAddSub(2'b11, 3'd2, 3'd0, 3'd1), 3'd2, b);
		c = b + 32'd1;
		f = arithFlags(b, 32'd1, 1'b0);
		emitReg(encAddSub(2'b10, 3'd3, 3'd2, 3'd1), 3'd3, c);
		f = arithFlags(a, a, 1'b0);
		emitReg(encAddSub(2'b00, 3'd4, 3'd0, 3'd0), 3'd4, a + a);
		f = arithFlags(32'd31, 32'd31, 1'b1);
		emitReg(encAddSub(2'b01, 3'd5, 3'd1, 3'd1), 3'd5, 32'd0);
		f = nzFlags(32'd0, f);
		emitReg(encMovs(3'd6, 8'd0), 3'd6, 32'd0);
		f = arithFlags(32'd0, 32'd31, 1'b1);
		emitReg(encAddSub(2'b01, 3'd7, 3'd6, 3'd1), 3'd7, 32'd0 - 32'd31);
		loadAndStart();
		runExpected();
	endtask

	task automatic testLogic();
		logic [7:0] x, y;
		logic [7:0] amts[5];
		logic [3:0] shOps[4];
		word_t r;
		clearProgram();
		f = '0;
		x = 8'($urandom);
		y = 8'($urandom);
		amts = '{8'd0, 8'd31, 8'd32, 8'd40, 8'(1 + $urandom % 30)};
		shOps = '{4'b0010, 4'b0011, 4'b0100, 4'b0111};
		// CMP 0x80000000 with 1 sets C and V, which must then survive
		f = nzFlags(32'd1, f);
		emitReg(encMovs(3'd6, 8'd1), 3'd6, 32'd1);
		f = nzFlags(32'd31, f);
		emitReg(encMovs(3'd7, 8'd31), 3'd7, 32'd31);
		f = nzFlags(32'h8000_0000, f);
		emitReg(encDp(4'b0010, 3'd6, 3'd7), 3'd6, 32'h8000_0000);
		f = nzFlags(32'd1, f);
		emitReg(encMovs(3'd7, 8'd1), 3'd7, 32'd1);
		f = arithFlags(32'h8000_0000, 32'd1, 1'b1);
		emitNone(encDp(4'b1010, 3'd6, 3'd7));
		f = nzFlags(32'(y), f);
		emitReg(encMovs(3'd1, y), 3'd1, 32'(y));
		for (int op = 0; op < 3; op++) begin
			f = nzFlags(32'(x), f);
			emitReg(encMovs(3'd0, x), 3'd0, 32'(x));
			r = (op == 0) ? 32'(x & y) : (op == 1) ? 32'(x ^ y) : 32'(x | y);
			f = nzFlags(r, f);
			emitReg(encDp((op == 0) ? 4'b0000 : (op == 1) ? 4'b0001 : 4'b1100, 3'd0, 3'd1),
				3'd0, r);
		end
		foreach (amts[i]) begin
			f = nzFlags(32'(amts[i]), f);
			emitReg(encMovs(3'd4, amts[i]), 3'd4, 32'(amts[i]));
			for (int d = 0; d < 4; d++) begin
				f = nzFlags(~32'(y), f);
				emitReg(encDp(4'b1111, 3'd3, 3'd1), 3'd3, ~32'(y));
				r = shiftModel(d, ~32'(y), amts[i]);
				f = nzFlags(r, f);
				emitReg(encDp(shOps[d], 3'd3, 3'd4), 3'd3, r);
			end
		end
		loadAndStart();
		runExpected();
	endtask

	task automatic testMemory();
		logic [7:0] v;
		clearProgram();
		f = '0;
		v = 8'($urandom) | 8'h80;
		f = nzFlags(32'(v), f);
		emitReg(encMovs(3'd0, v), 3'd0, 32'(v));
		f = nzFlags(32'd8, f);
		emitReg(encMovs(3'd1, 8'd8), 3'd1, 32'd8);
		emit(encMem(1'b0, 3'd0, 3'd1, 5'd3), 1'b0, 3'd0, 32'd0, 1'b1, 32'd8 + 32'd3 * 4,
			32'(v));
		emitReg(encMem(1'b1, 3'd2, 3'd1, 5'd3), 3'd2, 32'(v));
		emit(encMem(1'b0, 3'd1, 3'd1, 5'd0), 1'b0, 3'd0, 32'd0, 1'b1, 32'd8, 32'd8);
		emitReg(encMem(1'b1, 3'd3, 3'd1, 5'd3), 3'd3, 32'(v));
		emitReg(encMem(1'b1, 3'd4, 3'd1, 5'd0), 3'd4, 32'd8);
		loadAndStart();
		runExpected();
	endtask

	task automatic testBranches();
		logic [7:0] pa[5], pb[5];
		logic [7:0] off;
		flags_t fl;
		pc_t expPc;
		pa = '{8'd5, 8'd3, 8'd200, 8'h80, 8'h7F};
		pb = '{8'd5, 8'd200, 8'd3, 8'd1, 8'h80};
		foreach (pa[p]) begin
			for (int c = 0; c < 15; c++) begin
				clearProgram();
				off = c[0] ? 8'd3 : 8'hFC;
				prog = '{encMovs(3'd0, pa[p]), encMovs(3'd1, pb[p]), encMovs(3'd2, 8'd24),
					encDp(4'b0010, 3'd0, 3'd2), encDp(4'b0010, 3'd1, 3'd2),
					encDp(4'b1010, 3'd0, 3'd1), {4'b1101, 4'(c), off}};
				loadAndStart();
				waitPc(16'd6, 20);
				fl = arithFlags(32'(pa[p]) << 24, 32'(pb[p]) << 24, 1'b1);
				checkFlags("flags", fl, flags);
				expPc = condModel(c, fl) ? 16'd8 + {{8{off[7]}}, off} : 16'd7;
				@(posedge clk);
				#1;
				checkPc("pc", expPc, pc);
				run = 1'b0;
			end
		end
	endtask

	task automatic testFlow();
		clearProgram();
		for (int k = 0; k < 11; k++) begin
			prog.push_back(nopInstr);
		end
		prog[1] = undefInstr;
		prog[2] = {5'b11100, 11'd5};
		prog[4] = encMovs(3'd1, 8'd7);
		prog[5] = {5'b11100, 11'h7FD};
		prog[9] = encMovs(3'd0, 8'h55);
		prog[10] = {5'b11100, 11'h7F8};
		loadAndStart();
		stepCheck(16'd0, 1'b0, 16'd1);
		stepCheck(16'd1, 1'b0, 16'd2);
		// Reset flags survive NOOP and the undefined opcode
		checkFlags("flags", 4'b0000, flags);
		stepCheck(16'd2, 1'b0, 16'd9);
		stepCheck(16'd9, 1'b1, 16'd10);
		stepCheck(16'd10, 1'b0, 16'd4);
		run = 1'b0;
		repeat (4) begin
			stepCheck(16'd4, 1'b0, 16'd4);
		end
		run = 1'b1;
		stepCheck(16'd4, 1'b1, 16'd5);
		stepCheck(16'd5, 1'b0, 16'd4);
		run = 1'b0;
	endtask

	initial begin
		errors = 0;
		void'($urandom(32'hc4d0030b));
		rstN = 1'b0;
		run = 1'b0;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		repeat (3) @(posedge clk);
		#1 rstN = 1'b1;
		testArith();
		testLogic();
		testMemory();
		testBranches();
		testFlow();
		$display("Error count: %0d", errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* tests/cpuTop_props.sv */
// CPU strobe and PC properties
`timescale 1ns/1ps
module cpuTopProps import cpuTypesPkg::*, cpuIsaPkg::*; (
	input logic clk,
	input logic rstN,
	input logic run,
	input pc_t pc,
	input logic regWe,
	input logic memWe,
	input brSel_e brSel
);

	// A store never writes a register
	strobesExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(regWe && memWe)) else $error("regWe and memWe high together");

	pcHoldsStalled: assert property (@(posedge clk) disable iff (!rstN)
		!run |=> pc == $past(pc)) else $error("PC moved while run was low");

	pcSteps: assert property (@(posedge clk) disable iff (!rstN)
		(run && brSel == brNext) |=> pc == $past(pc) + 16'd1)
		else $error("PC did not advance by one");

endmodule

bind cpuTop cpuTopProps props (.clk, .rstN, .run, .pc, .regWe, .memWe, .brSel(brSel));

/* hdl/cpuTop.sv */
// Single-cycle Thumb subset CPU
`timescale 1ns/1ps
module cpuTop import cpuTypesPkg::*, cpuIsaPkg::*; #(
	parameter int imemAddrBits = 8,
	parameter int dmemAddrBits = 6
) (
	input logic clk,
	input logic rstN,
	input logic run,
	input logic imemWe,
	input pc_t imemAddr,
	input instr_t imemData,
	output pc_t pc,
	output logic regWe,
	output regAddr_t regWrAddr,
	output word_t regWrData,
	output logic memWe,
	output word_t memAddr,
	output word_t memWrData,
	output flags_t flags
);

	instr_t instr;
	logic ctrlRegWe, ctrlMemWe, memRe;
	flags_t flagMask, aluFlags, flagsNext;
	aluOp_e aluOp;
	shiftDir_e shiftDir;
	opBSel_e opBSel;
	wrSel_e wrSel;
	brSel_e brSel;
	logic isDataProc, isLdrStr, isMovImm;
	regAddr_t rdAddrA, rdAddrB, wrAddr;
	word_t rdDataA, rdDataB, opB, aluResult, shiftResult, memRdData, immWord, wbData;

	cpuFetch #(.imemAddrBits(imemAddrBits)) fetch (.clk, .rstN, .run, .imemWe, .imemAddr,
		.imemData, .brSel, .pc, .instr);

	cpuControl control (.instr, .flags, .regWe(ctrlRegWe), .memWe(ctrlMemWe), .memRe,
		.flagMask, .aluOp, .shiftDir, .opBSel, .wrSel, .brSel);

	// Register fields sit where each format puts them
	assign isDataProc = (instr[15:10] == 6'b010000);
	assign isLdrStr = (instr[15:12] == 4'b0110);
	assign isMovImm = (instr[15:11] == 5'b00100);
	assign rdAddrA = isDataProc ? instr[2:0] : instr[5:3];
	assign rdAddrB = isDataProc ? instr[5:3] : (isLdrStr ? instr[2:0] : instr[8:6]);
	assign wrAddr = isMovImm ? instr[10:8] : instr[2:0];

	cpuRegFile regFile (.clk, .rstN, .we(regWe), .wrAddr, .rdAddrA, .rdAddrB,
		.wrData(wbData), .rdDataA, .rdDataB);

	always_comb begin
		case (opBSel)
			opbImm3: opB = {29'b0, instr[8:6]};
			opbImm5Word: opB = {25'b0, instr[10:6], 2'b00};
			default: opB = rdDataB;
		endcase
	end

	cpuAlu alu (.a(rdDataA), .b(opB), .aluOp, .shiftDir, .flagsIn(flags), .aluResult,
		.shiftResult, .flagsOut(aluFlags));

	cpuDataMem #(.dmemAddrBits(dmemAddrBits)) dataMem (.clk, .we(memWe), .addr(aluResult),
		.wrData(rdDataB), .rdData(memRdData));

	assign immWord = {24'b0, instr[7:0]};

	always_comb begin
		case (wrSel)
			wrShift: wbData = shiftResult;
			wrImm: wbData = immWord;
			wrMem: wbData = memRdData;
			default: wbData = aluResult;
		endcase
	end

	// MOVS takes N and Z from the immediate
	always_comb begin
		flagsNext = aluFlags;
		if (wrSel == wrImm) begin
			flagsNext[flagN] = immWord[31];
			flagsNext[flagZ] = (immWord == '0);
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			flags <= '0;
		end else if (run) begin
			flags <= (flags & ~flagMask) | (flagsNext & flagMask);
		end
	end

	// Strobes and their payloads are quiet while stalled
	assign regWe = run && ctrlRegWe;
	assign memWe = run && ctrlMemWe;
	assign regWrAddr = regWe ? wrAddr : '0;
	assign regWrData = regWe ? wbData : '0;
	assign memAddr = (run && (ctrlMemWe || memRe)) ? aluResult : '0;
	assign memWrData = memWe ? rdDataB : '0;

endmodule

/* hdl/cpuDataMem.sv */
// Word-addressed data memory
`timescale 1ns/1ps
module cpuDataMem import cpuTypesPkg::*; #(
	parameter int dmemAddrBits = 6
) (
	input logic clk,
	input logic we,
	input word_t addr,
	input word_t wrData,
	output word_t rdData
);

	word_t mem [2**dmemAddrBits];
	logic [dmemAddrBits-1:0] wordIdx;

	// Byte address to word index
	assign wordIdx = addr[dmemAddrBits+1:2];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[wordIdx] <= wrData;
		end
	end

	// Loads complete in the same cycle
	assign rdData = mem[wordIdx];

endmodule

/* hdl/cpuAlu.sv */
// ALU and barrel shifter
`timescale 1ns/1ps
module cpuAlu import cpuTypesPkg::*, cpuIsaPkg::*; (
	input word_t a,
	input word_t b,
	input aluOp_e aluOp,
	input shiftDir_e shiftDir,
	input flags_t flagsIn,
	output word_t aluResult,
	output word_t shiftResult,
	output flags_t flagsOut
);

	logic [32:0] sum;
	logic [7:0] shAmt;
	logic [63:0] rotPair;
	word_t nzSource;

	// Only the low byte of the amount register counts
	assign shAmt = b[7:0];
	assign rotPair = {a, a} >> shAmt[4:0];

	always_comb begin
		sum = '0;
		case (aluOp)
			opAdd: sum = {1'b0, a} + {1'b0, b};
			// Carry out here means no borrow
			opSub: sum = {1'b0, a} + {1'b0, ~b} + 33'd1;
			default: sum = '0;
		endcase

		case (aluOp)
			opAdd, opSub: aluResult = sum[31:0];
			opAnd: aluResult = a & b;
			opOrr: aluResult = a | b;
			opEor: aluResult = a ^ b;
			opMvn: aluResult = ~b;
			default: aluResult = b;
		endcase
	end

	always_comb begin
		case (shiftDir)
			shLsl: shiftResult = (shAmt > 8'd31) ? '0 : a << shAmt[4:0];
			shLsr: shiftResult = (shAmt > 8'd31) ? '0 : a >> shAmt[4:0];
			shAsr: shiftResult = (shAmt > 8'd31) ? {32{a[31]}} :
				word_t'($signed(a) >>> shAmt[4:0]);
			default: shiftResult = rotPair[31:0];
		endcase
	end

	// N and Z follow whichever path produces the result
	always_comb begin
		nzSource = (aluOp == opPass) ? shiftResult : aluResult;
		flagsOut = flagsIn;
		flagsOut[flagN] = nzSource[31];
		flagsOut[flagZ] = (nzSource == '0);
		if (aluOp == opAdd) begin
			flagsOut[flagC] = sum[32];
			flagsOut[flagV] = (a[31] == b[31]) && (sum[31] != a[31]);
		end else if (aluOp == opSub) begin
			flagsOut[flagC] = sum[32];
			flagsOut[flagV] = (a[31] != b[31]) && (sum[31] != a[31]);
		end
	end

endmodule

/* hdl/cpuRegFile.sv */
// Low register file
`timescale 1ns/1ps
module cpuRegFile import cpuTypesPkg::*; (
	input logic clk,
	input logic rstN,
	input logic we,
	input regAddr_t wrAddr,
	input regAddr_t rdAddrA,
	input regAddr_t rdAddrB,
	input word_t wrData,
	output word_t rdDataA,
	output word_t rdDataB
);

	word_t regs [8];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Reads see the value before this cycle's write
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

/* hdl/cpuFetch.sv */
// Program counter and instruction memory
`timescale 1ns/1ps
module cpuFetch import cpuTypesPkg::*, cpuIsaPkg::*; #(
	parameter int imemAddrBits = 8
) (
	input logic clk,
	input logic rstN,
	input logic run,
	input logic imemWe,
	input pc_t imemAddr,
	input instr_t imemData,
	input brSel_e brSel,
	output pc_t pc,
	output instr_t instr
);

	instr_t imem [2**imemAddrBits];
	pc_t pcNext;
	pc_t condOffset;
	pc_t uncondOffset;

	// Program load port
	always_ff @(posedge clk) begin
		if (imemWe) begin
			imem[imemAddr[imemAddrBits-1:0]] <= imemData;
		end
	end

	assign instr = imem[pc[imemAddrBits-1:0]];

	// Branch offsets in halfwords
	assign condOffset = {{8{instr[7]}}, instr[7:0]};
	assign uncondOffset = {{5{instr[10]}}, instr[10:0]};

	// Targets are relative to PC + 2, the architectural PC + 4 bytes
	always_comb begin
		case (brSel)
			brCond: pcNext = pc + 16'd2 + condOffset;
			brUncond: pcNext = pc + 16'd2 + uncondOffset;
			default: pcNext = pc + 16'd1;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
		end else if (run) begin
			pc <= pcNext;
		end
	end

endmodule

/* hdl/cpuControl.sv */
// Thumb instruction decoder
`timescale 1ns/1ps
module cpuControl import cpuTypesPkg::*, cpuIsaPkg::*; (
	input instr_t instr,
	input flags_t flags,
	output logic regWe,
	output logic memWe,
	output logic memRe,
	output flags_t flagMask,
	output aluOp_e aluOp,
	output shiftDir_e shiftDir,
	output opBSel_e opBSel,
	output wrSel_e wrSel,
	output brSel_e brSel
);

	logic [9:0] opcode;
	logic condPass;

	assign opcode = instr[15:6];

	// Condition code of the Bcond format
	always_comb begin
		case (instr[11:8])
			4'h0: condPass = flags[flagZ];
			4'h1: condPass = !flags[flagZ];
			4'h2: condPass = flags[flagC];
			4'h3: condPass = !flags[flagC];
			4'h4: condPass = flags[flagN];
			4'h5: condPass = !flags[flagN];
			4'h6: condPass = flags[flagV];
			4'h7: condPass = !flags[flagV];
			4'h8: condPass = flags[flagC] && !flags[flagZ];
			4'h9: condPass = !flags[flagC] || flags[flagZ];
			4'hA: condPass = flags[flagN] == flags[flagV];
			4'hB: condPass = flags[flagN] != flags[flagV];
			4'hC: condPass = !flags[flagZ] && (flags[flagN] == flags[flagV]);
			4'hD: condPass = flags[flagZ] || (flags[flagN] != flags[flagV]);
			4'hE: condPass = 1'b1;
			// SVC encoding is not supported
			default: condPass = 1'b0;
		endcase
	end

	always_comb begin
		// Anything not listed below behaves as a no-op
		regWe = 1'b0;
		memWe = 1'b0;
		memRe = 1'b0;
		flagMask = 4'b0000;
		aluOp = opPass;
		shiftDir = shLsl;
		opBSel = opbReg;
		wrSel = wrAlu;
		brSel = brNext;

		casez (opcode)
			// MOVS Rd, #imm8
			10'b00100_?????: begin
				regWe = 1'b1;
				flagMask = 4'b1100;
				wrSel = wrImm;
			end
			// ADDS and SUBS, register and imm3 forms
			10'b0001100_???, 10'b0001101_???, 10'b0001110_???, 10'b0001111_???: begin
				regWe = 1'b1;
				flagMask = 4'b1111;
				aluOp = opcode[3] ? opSub : opAdd;
				opBSel = opcode[4] ? opbImm3 : opbReg;
			end
			// CMP Rn, Rm
			10'b0100001010: begin
				flagMask = 4'b1111;
				aluOp = opSub;
			end
			10'b0100000000, 10'b0100000001, 10'b0100001100, 10'b0100001111: begin
				regWe = 1'b1;
				flagMask = 4'b1100;
				case (opcode[3:0])
					4'b0000: aluOp = opAnd;
					4'b0001: aluOp = opEor;
					4'b1100: aluOp = opOrr;
					default: aluOp = opMvn;
				endcase
			end
			// Shifts by register
			10'b0100000010, 10'b0100000011, 10'b0100000100, 10'b0100000111: begin
				regWe = 1'b1;
				flagMask = 4'b1100;
				wrSel = wrShift;
				case (opcode[2:0])
					3'b010: shiftDir = shLsl;
					3'b011: shiftDir = shLsr;
					3'b100: shiftDir = shAsr;
					default: shiftDir = shRor;
				endcase
			end
			// STR Rt, [Rn, #imm5]
			10'b01100_?????: begin
				memWe = 1'b1;
				aluOp = opAdd;
				opBSel = opbImm5Word;
			end
			// LDR Rt, [Rn, #imm5]
			10'b01101_?????: begin
				regWe = 1'b1;
				memRe = 1'b1;
				aluOp = opAdd;
				opBSel = opbImm5Word;
				wrSel = wrMem;
			end
			10'b1101_??????: brSel = condPass ? brCond : brNext;
			10'b11100_?????: brSel = brUncond;
			// NOOP keeps the defaults
			10'b1011111100: ;
			default: ;
		endcase
	end

endmodule

/* hdl/cpuIsaPkg.sv */
// Decoder select codes
package cpuIsaPkg;

	// ALU operation, opPass hands flags over to the shifter
	typedef enum logic [2:0] {
		opAdd,
		opSub,
		opAnd,
		opOrr,
		opEor,
		opMvn,
		opPass
	} aluOp_e;

	// Barrel shifter mode
	typedef enum logic [1:0] {
		shLsl,
		shLsr,
		shAsr,
		shRor
	} shiftDir_e;

	// Register write-back source
	typedef enum logic [1:0] {
		wrShift,
		wrAlu,
		wrImm,
		wrMem
	} wrSel_e;

	// Next-PC source
	typedef enum logic [1:0] {
		brNext,
		brCond,
		brUncond
	} brSel_e;

	// ALU operand B source
	typedef enum logic [1:0] {
		opbReg,
		opbImm3,
		opbImm5Word
	} opBSel_e;

endpackage

/* hdl/cpuTypesPkg.sv */
// Datapath word and field types
package cpuTypesPkg;

	// 32-bit register and memory word
	typedef logic [31:0] word_t;

	// 16-bit Thumb instruction
	typedef logic [15:0] instr_t;

	// Program counter, counts halfword instructions
	typedef logic [15:0] pc_t;

	// Low register number, r0 to r7
	typedef logic [2:0] regAddr_t;

	// Condition flags, N Z C V from the top bit down
	typedef logic [3:0] flags_t;

	// Bit positions inside flags_t
	localparam int flagN = 3;
	localparam int flagZ = 2;
	localparam int flagC = 1;
	localparam int flagV = 0;

endpackage
